// ==== ps2KbdPkg.sv ====
package ps2KbdPkg;

    typedef logic [7:0] scanCode_t;

    // Bit 0 is the top segment, 1 to 5 go clockwise, 6 is the middle
    typedef logic [6:0] segPattern_t;

    typedef struct packed {
        logic ps2Clk;
        logic ps2Data;
    } ps2Lines_t;

    typedef struct packed {
        logic      keyHeld;
        scanCode_t keyCode;
        logic [7:0] keyCount;
    } keyState_t;

    typedef struct packed {
        segPattern_t countHi;
        segPattern_t countLo;
        segPattern_t asciiHi;
        segPattern_t asciiLo;
        segPattern_t codeHi;
        segPattern_t codeLo;
    } displayDigits_t;

    localparam int FrameBits = 10;               // Data, parity and stop after the start bit

    localparam scanCode_t BreakPrefix  = 8'hF0;
    localparam scanCode_t ExtendPrefix = 8'hE0;

    localparam segPattern_t SegBlank = 7'b0000000;

    function automatic segPattern_t hexSegments(input logic [3:0] nibble);
        segPattern_t pattern;
        pattern = SegBlank;                       // Only reached for unknown input
        case (nibble)
            4'h0: pattern = 7'b0111111;
            4'h1: pattern = 7'b0000110;
            4'h2: pattern = 7'b1011011;
            4'h3: pattern = 7'b1001111;
            4'h4: pattern = 7'b1100110;
            4'h5: pattern = 7'b1101101;
            4'h6: pattern = 7'b1111101;
            4'h7: pattern = 7'b0000111;
            4'h8: pattern = 7'b1111111;
            4'h9: pattern = 7'b1101111;
            4'hA: pattern = 7'b1110111;
            4'hB: pattern = 7'b1111100;           // Lower-case b
            4'hC: pattern = 7'b0111001;
            4'hD: pattern = 7'b1011110;           // Lower-case d
            4'hE: pattern = 7'b1111001;
            4'hF: pattern = 7'b1110001;
        endcase
        return pattern;
    endfunction

endpackage

// ==== ps2Receiver.sv ====
`timescale 1ns/1ps

module ps2Receiver #(
    parameter int SyncStages = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ps2KbdPkg::ps2Lines_t ps2,
    output ps2KbdPkg::scanCode_t code,
    output logic                 codeValid
);
    import ps2KbdPkg::*;

    localparam int CountWidth = $clog2(FrameBits + 1);

    ps2Lines_t [SyncStages-1:0] syncChain;       // Both lines go through the same chain
    ps2Lines_t                  lines;
    logic                       prevClk;
    logic                       fallingEdge;
    logic [FrameBits-1:0]       frame;           // Start, eight data bits, parity
    logic [CountWidth-1:0]      bitCount;
    logic                       lastBit;
    logic                       frameGood;

    assign lines       = syncChain[SyncStages-1];
    assign fallingEdge = prevClk & ~lines.ps2Clk;
    assign lastBit     = bitCount == CountWidth'(FrameBits);

    // Start low, stop high, odd parity over data and parity bit
    assign frameGood = ~frame[0] & lines.ps2Data & (^frame[FrameBits-1:1]);

    always_ff @(posedge clk) begin
        if (reset) begin
            syncChain <= '1;                     // Lines idle high
            prevClk   <= 1'b1;
        end else begin
            syncChain <= {syncChain[SyncStages-2:0], ps2};
            prevClk   <= lines.ps2Clk;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bitCount  <= '0;
            codeValid <= 1'b0;
        end else begin
            codeValid <= 1'b0;
            if (fallingEdge) begin
                if (lastBit) begin
                    codeValid <= frameGood;      // Bad frames vanish here
                    bitCount  <= '0;
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fallingEdge) begin
            if (!lastBit) begin
                frame[bitCount] <= lines.ps2Data;
            end else if (frameGood) begin
                code <= frame[FrameBits-2:1];    // Held until the next good frame
            end
        end
    end

endmodule

// ==== keyEventTracker.sv ====
`timescale 1ns/1ps

module keyEventTracker (
    input  logic                 clk,
    input  logic                 reset,
    input  ps2KbdPkg::scanCode_t code,
    input  logic                 codeValid,
    output ps2KbdPkg::keyState_t state
);
    import ps2KbdPkg::*;

    logic       keyHeld;
    scanCode_t  keyCode;
    logic [7:0] keyCount;
    logic       breakPending;
    logic       extendPending;
    logic       isBreak;
    logic       isExtend;

    assign isBreak  = code == BreakPrefix;
    assign isExtend = code == ExtendPrefix;

    // Prefix bytes only arm a flag; the byte after them does the work
    always_ff @(posedge clk) begin
        if (reset) begin
            keyHeld       <= 1'b0;
            keyCount      <= '0;
            breakPending  <= 1'b0;
            extendPending <= 1'b0;
        end else if (codeValid) begin
            if (isBreak) begin
                breakPending <= 1'b1;
            end else if (isExtend) begin
                extendPending <= 1'b1;
            end else if (extendPending) begin
                extendPending <= 1'b0;           // Extended key is dropped
                breakPending  <= 1'b0;
            end else if (breakPending) begin
                breakPending <= 1'b0;
                keyHeld      <= 1'b0;            // Release
            end else if (!keyHeld) begin
                keyHeld  <= 1'b1;
                keyCount <= keyCount + 8'd1;     // Wraps FF to 00
            end
        end
    end

    // Typematic repeats arrive while keyHeld is set and are ignored
    always_ff @(posedge clk) begin
        if (codeValid && !isBreak && !isExtend && !extendPending && !breakPending
                && !keyHeld) begin
            keyCode <= code;
        end
    end

    assign state.keyHeld  = keyHeld;
    assign state.keyCode  = keyCode;
    assign state.keyCount = keyCount;

endmodule

// ==== asciiRom.sv ====
`timescale 1ns/1ps

module asciiRom (
    input  ps2KbdPkg::scanCode_t scanCode,
    output ps2KbdPkg::scanCode_t ascii
);

    // Set-2 make codes, lower-case letters and top-row digits
    always_comb begin
        case (scanCode)
            8'h1C: ascii = 8'h61;   // a
            8'h32: ascii = 8'h62;   // b
            8'h21: ascii = 8'h63;   // c
            8'h23: ascii = 8'h64;   // d
            8'h24: ascii = 8'h65;   // e
            8'h2B: ascii = 8'h66;   // f
            8'h34: ascii = 8'h67;   // g
            8'h33: ascii = 8'h68;   // h
            8'h43: ascii = 8'h69;   // i
            8'h3B: ascii = 8'h6A;   // j
            8'h42: ascii = 8'h6B;   // k
            8'h4B: ascii = 8'h6C;   // l
            8'h3A: ascii = 8'h6D;   // m
            8'h31: ascii = 8'h6E;   // n
            8'h44: ascii = 8'h6F;   // o
            8'h4D: ascii = 8'h70;   // p
            8'h15: ascii = 8'h71;   // q
            8'h2D: ascii = 8'h72;   // r
            8'h1B: ascii = 8'h73;   // s
            8'h2C: ascii = 8'h74;   // t
            8'h3C: ascii = 8'h75;   // u
            8'h2A: ascii = 8'h76;   // v
            8'h1D: ascii = 8'h77;   // w
            8'h22: ascii = 8'h78;   // x
            8'h35: ascii = 8'h79;   // y
            8'h1A: ascii = 8'h7A;   // z
            8'h45: ascii = 8'h30;   // 0
            8'h16: ascii = 8'h31;   // 1
            8'h1E: ascii = 8'h32;   // 2
            8'h26: ascii = 8'h33;   // 3
            8'h25: ascii = 8'h34;   // 4
            8'h2E: ascii = 8'h35;   // 5
            8'h36: ascii = 8'h36;   // 6
            8'h3D: ascii = 8'h37;   // 7
            8'h3E: ascii = 8'h38;   // 8
            8'h46: ascii = 8'h39;   // 9
            default: ascii = 8'h00; // Not a character key
        endcase
    end

endmodule

// ==== hexDisplay.sv ====
`timescale 1ns/1ps

module hexDisplay (
    input  ps2KbdPkg::scanCode_t   value,
    input  logic                   blank,
    output ps2KbdPkg::segPattern_t high,
    output ps2KbdPkg::segPattern_t low
);
    import ps2KbdPkg::*;

    segPattern_t highPattern;
    segPattern_t lowPattern;

    assign highPattern = hexSegments(value[7:4]);
    assign lowPattern  = hexSegments(value[3:0]);

    assign high = blank ? SegBlank : highPattern;   // Both digits go dark together
    assign low  = blank ? SegBlank : lowPattern;

endmodule

// ==== keyboardDisplay.sv ====
`timescale 1ns/1ps

module keyboardDisplay #(
    parameter int SyncStages = 3
) (
    input  logic                           clk,
    input  logic                           reset,
    input  ps2KbdPkg::ps2Lines_t           ps2,
    output wire ps2KbdPkg::displayDigits_t digits
);
    import ps2KbdPkg::*;

    scanCode_t code;
    logic      codeValid;
    keyState_t state;
    scanCode_t ascii;

    ps2Receiver #(
        .SyncStages(SyncStages)
    ) receiver (
        .clk      (clk),
        .reset    (reset),
        .ps2      (ps2),
        .code     (code),
        .codeValid(codeValid)
    );

    keyEventTracker tracker (
        .clk      (clk),
        .reset    (reset),
        .code     (code),
        .codeValid(codeValid),
        .state    (state)
    );

    asciiRom rom (
        .scanCode(state.keyCode),
        .ascii   (ascii)
    );

    hexDisplay countDisplay (               // Stays lit after a release
        .value(state.keyCount),
        .blank(1'b0),
        .high (digits.countHi),
        .low  (digits.countLo)
    );

    hexDisplay asciiDisplay (
        .value(ascii),
        .blank(!state.keyHeld),
        .high (digits.asciiHi),
        .low  (digits.asciiLo)
    );

    hexDisplay codeDisplay (
        .value(state.keyCode),
        .blank(!state.keyHeld),
        .high (digits.codeHi),
        .low  (digits.codeLo)
    );

endmodule

// ==== keyboardDisplay_properties.sv ====
`timescale 1ns/1ps

module keyboardDisplay_properties (
    input logic       clk,
    input logic       reset,
    input logic       codeValid,
    input logic       keyHeld,
    input logic [7:0] keyCount,
    input logic       extendPending
);

    // Count moves only right after a strobe, one step at a time
    countStep: assert property (@(posedge clk) disable iff (reset)
        keyCount != $past(keyCount) |-> $past(codeValid) && keyCount == $past(keyCount) + 8'd1)
        else $error("keyCount changed without a strobe or by more than one");

    releasedAfterReset: assert property (@(posedge clk)
        reset |=> !keyHeld)
        else $error("keyHeld set in the cycle after reset");

    // Extended keys never reach the count
    extendHoldsCount: assert property (@(posedge clk) disable iff (reset)
        extendPending |=> keyCount == $past(keyCount))
        else $error("keyCount changed while an extended key was pending");

endmodule

bind keyEventTracker keyboardDisplay_properties trackerProps (
    .clk          (clk),
    .reset        (reset),
    .codeValid    (codeValid),
    .keyHeld      (keyHeld),
    .keyCount     (keyCount),
    .extendPending(extendPending)
);

// ==== keyboardDisplayTb.sv ====
`timescale 1ns/1ps

module keyboardDisplayTb;
    import ps2KbdPkg::*;

    localparam int ResetCycles    = 10;
    localparam int HalfPeriod     = 20;      // System clocks per PS/2 clock half
    localparam int DisplayTimeout = 200;

    // Set-2 make codes in alphabetical and numeric order
    localparam scanCode_t LetterCodes [26] = '{
        8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43, 8'h3B,
        8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D, 8'h1B, 8'h2C,
        8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
    };
    localparam scanCode_t DigitCodes [10] = '{
        8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
    };
    localparam scanCode_t EnterCode = 8'h5A;
    localparam scanCode_t UpArrow   = 8'h75;    // Sent after E0

    logic           clk;
    logic           reset;
    ps2Lines_t      ps2;
    displayDigits_t digits;

    // Reference model of the key state
    logic        modelHeld = 1'b0;
    scanCode_t   modelCode = 8'h00;
    logic [7:0]  modelCount = 8'h00;

    int          errorCount = 0;
    int          testCount = 0;
    int          failedTests = 0;
    int unsigned lcgState = 93676;

    keyboardDisplay #(
        .SyncStages(3)
    ) uut (
        .clk   (clk),
        .reset (reset),
        .ps2   (ps2),
        .digits(digits)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;                  // Low bits of an LCG repeat quickly
    endfunction

    function automatic scanCode_t randomKey();
        int unsigned pick;
        pick = nextRandom() % 36;
        if (pick < 26) begin
            return LetterCodes[pick];
        end
        return DigitCodes[pick - 26];
    endfunction

    function automatic segPattern_t digitPattern(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic scanCode_t asciiFor(input scanCode_t code);
        scanCode_t result;
        result = 8'h00;                         // Non-character keys
        for (int i = 0; i < 26; i++) begin
            if (LetterCodes[i] == code) begin
                result = 8'h61 + 8'(i);
            end
        end
        for (int i = 0; i < 10; i++) begin
            if (DigitCodes[i] == code) begin
                result = 8'h30 + 8'(i);
            end
        end
        return result;
    endfunction

    function automatic displayDigits_t expectedDigits(input logic held, input scanCode_t code,
            input logic [7:0] count);
        displayDigits_t result;
        scanCode_t      ascii;
        ascii = asciiFor(code);
        result.countHi = digitPattern(count[7:4]);
        result.countLo = digitPattern(count[3:0]);
        if (held) begin
            result.asciiHi = digitPattern(ascii[7:4]);
            result.asciiLo = digitPattern(ascii[3:0]);
            result.codeHi  = digitPattern(code[7:4]);
            result.codeLo  = digitPattern(code[3:0]);
        end else begin
            result.asciiHi = 7'h00;             // All four low digits dark
            result.asciiLo = 7'h00;
            result.codeHi  = 7'h00;
            result.codeLo  = 7'h00;
        end
        return result;
    endfunction

    task automatic waitClocks(input int cycles);
        repeat (cycles) @(negedge clk);
    endtask

    task automatic compareDigit(input string testName, input string digitName,
            input segPattern_t expected, input segPattern_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s: expected %h actual %h", testName, digitName,
                     expected, actual);
            errorCount++;
        end
    endtask

    task automatic compareDigits(input string testName, input displayDigits_t expected,
            input displayDigits_t actual);
        compareDigit(testName, "countHi", expected.countHi, actual.countHi);
        compareDigit(testName, "countLo", expected.countLo, actual.countLo);
        compareDigit(testName, "asciiHi", expected.asciiHi, actual.asciiHi);
        compareDigit(testName, "asciiLo", expected.asciiLo, actual.asciiLo);
        compareDigit(testName, "codeHi", expected.codeHi, actual.codeHi);
        compareDigit(testName, "codeLo", expected.codeLo, actual.codeLo);
    endtask

    task automatic waitForDigits(input string testName);
        displayDigits_t expected;
        int             waited;
        expected = expectedDigits(modelHeld, modelCode, modelCount);
        waited = 0;
        while (digits !== expected && waited < DisplayTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (digits !== expected) begin
            $display("%s: display did not settle within %0d cycles", testName, DisplayTimeout);
        end
        compareDigits(testName, expected, digits);
    endtask

    task automatic sendByte(input scanCode_t value, input logic badParity);
        logic [10:0] frame;
        logic        parity;
        parity = ~(^value);                     // Odd parity
        if (badParity) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, value, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 11; i++) begin
            ps2.ps2Data = frame[i];             // PS/2 clock is high here
            waitClocks(HalfPeriod / 2);
            ps2.ps2Clk = 1'b0;
            waitClocks(HalfPeriod);
            ps2.ps2Clk = 1'b1;
            waitClocks(HalfPeriod / 2);
        end
        ps2.ps2Data = 1'b1;
        waitClocks(HalfPeriod);                 // Idle gap between frames
    endtask

    task automatic pressKey(input scanCode_t code, input string testName);
        sendByte(code, 1'b0);
        if (!modelHeld) begin                   // Repeats of a held key change nothing
            modelHeld  = 1'b1;
            modelCode  = code;
            modelCount = modelCount + 8'd1;
        end
        waitForDigits(testName);
    endtask

    task automatic releaseKey(input scanCode_t code, input string testName);
        sendByte(BreakPrefix, 1'b0);
        waitForDigits(testName);                // Prefix alone leaves the key shown
        sendByte(code, 1'b0);
        modelHeld = 1'b0;
        waitForDigits(testName);
    endtask

    task automatic finishTest(input string testName, input int errorsAtStart);
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("PASS %s", testName);
        end else begin
            failedTests++;
            $display("FAIL %s with %0d errors", testName, errorCount - errorsAtStart);
        end
    endtask

    task automatic resetTest();
        int errorsAtStart;
        errorsAtStart = errorCount;
        waitForDigits("reset");
        finishTest("reset", errorsAtStart);
    endtask

    task automatic letterKeyTest();
        int        errorsAtStart;
        scanCode_t key;
        errorsAtStart = errorCount;
        key = LetterCodes[nextRandom() % 26];
        pressKey(key, "letter key");
        releaseKey(key, "letter key");
        finishTest("letter key", errorsAtStart);
    endtask

    task automatic repeatTest();
        int        errorsAtStart;
        scanCode_t key;
        errorsAtStart = errorCount;
        key = DigitCodes[nextRandom() % 10];
        repeat (3) begin
            pressKey(key, "typematic repeat");
        end
        releaseKey(key, "typematic repeat");
        finishTest("typematic repeat", errorsAtStart);
    endtask

    task automatic badParityTest();
        int        errorsAtStart;
        scanCode_t key;
        errorsAtStart = errorCount;
        key = randomKey();
        sendByte(key, 1'b1);                    // Dropped by the receiver
        waitForDigits("bad parity");
        pressKey(key, "bad parity");
        releaseKey(key, "bad parity");
        finishTest("bad parity", errorsAtStart);
    endtask

    task automatic extendedKeyTest();
        int errorsAtStart;
        errorsAtStart = errorCount;
        sendByte(ExtendPrefix, 1'b0);
        sendByte(UpArrow, 1'b0);
        waitForDigits("extended key");
        sendByte(ExtendPrefix, 1'b0);
        sendByte(BreakPrefix, 1'b0);
        sendByte(UpArrow, 1'b0);
        waitForDigits("extended key");
        pressKey(EnterCode, "extended key");    // Shows its code with ASCII 00
        releaseKey(EnterCode, "extended key");
        finishTest("extended key", errorsAtStart);
    endtask

    task automatic wrapTest();
        int        errorsAtStart;
        int        presses;
        logic      wrapped;
        scanCode_t key;
        errorsAtStart = errorCount;
        presses = 0;
        wrapped = 1'b0;
        while (!wrapped && presses < 300) begin
            key = randomKey();
            pressKey(key, "count wrap");
            wrapped = modelCount == 8'h00;
            releaseKey(key, "count wrap");
            presses++;
        end
        key = randomKey();                      // One step past the wrap
        pressKey(key, "count wrap");
        releaseKey(key, "count wrap");
        finishTest("count wrap", errorsAtStart);
    endtask

    initial begin
        reset = 1'b1;
        ps2.ps2Clk = 1'b1;
        ps2.ps2Data = 1'b1;
        waitClocks(ResetCycles);
        reset = 1'b0;
        resetTest();
        letterKeyTest();
        repeatTest();
        badParityTest();
        extendedKeyTest();
        wrapTest();
        $display("Tests run %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
ps2KbdPkg.sv
ps2Receiver.sv
keyEventTracker.sv
asciiRom.sv
hexDisplay.sv
keyboardDisplay.sv
keyboardDisplay_properties.sv
keyboardDisplayTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -f vlog.f --top-module keyboardDisplayTb > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/VkeyboardDisplayTb > sim.log 2>&1
simStatus=$?
cat sim.log
grep -qF '*** TEST FAILED ***' sim.log && { echo "Simulation reported failure"; exit 1; }
[ "$simStatus" -eq 0 ] || { echo "Simulation exited with status $simStatus"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0
